//--- board_eval.f
verilog/eval_pkg.sv
verilog/eval_bus_if.sv
verilog/eval_control.sv
verilog/rank_score.sv
verilog/phase_blend.sv
verilog/board_eval.sv
sim/tb_clock.sv
sim/tb_board_eval.sv

//--- Makefile
# Verilator build and run of the board evaluator testbench

TOP       ?= tb_board_eval
FILELIST  ?= board_eval.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Run passed"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_board_eval.sv
////////////////////////////////////////////////////////////
// Board evaluator directed tests
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_board_eval;
   import eval_pkg::*;

   localparam int ADVANCE    = 8;                           // Pawn end-game bonus per rank
   localparam int MAX_WAIT   = 40;                          // Cycles before a wait gives up
   localparam int RANDOM_RUN = 20;

   logic   clk;
   logic   reset;
   logic   board_valid;
   board_t board_in;
   logic   clear_eval;
   score_t eval;
   logic   eval_valid;
   int     seed;

   tb_clock clock_i
   (
      .clk   (clk),
      .reset (reset)
   );

   board_eval #(.PAWN_ADVANCE_EG(ADVANCE)) dut_i
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic compare_score(input score_t got, input score_t exp, input string what);
      if (got !== exp)
         stop_on_error($sformatf("ERROR at %0t: %s eval %0d, expected %0d",
                                 $time, what, got, exp));
   endtask

   task automatic compare_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
         stop_on_error($sformatf("ERROR at %0t: %s eval_valid %b, expected %b",
                                 $time, what, got, exp));
   endtask

   task automatic compare_count(input int got, input int exp, input string what);
      if (got != exp)
         stop_on_error($sformatf("ERROR at %0t: %s latency %0d cycles, expected %0d",
                                 $time, what, got, exp));
   endtask

   // Material tables, middle game then end game
   function automatic int mg_value(input logic [2:0] kind);
      case (kind)
         PIECE_PAWN:   return 82;
         PIECE_KNIGHT: return 337;
         PIECE_BISHOP: return 365;
         PIECE_ROOK:   return 477;
         PIECE_QUEEN:  return 1025;
         default:      return 0;                            // Empty and king
      endcase
   endfunction

   function automatic int eg_value(input logic [2:0] kind);
      case (kind)
         PIECE_PAWN:   return 94;
         PIECE_KNIGHT: return 281;
         PIECE_BISHOP: return 297;
         PIECE_ROOK:   return 512;
         PIECE_QUEEN:  return 936;
         default:      return 0;
      endcase
   endfunction

   // Reference eval of a whole board
   function automatic score_t expected_eval(input board_t b);
      piece_t sq;
      int     rank;
      int     mg;
      int     eg;
      int     pieces;
      int     phase;
      int     pmg;
      int     peg;
      longint blended;
      longint scaled;
      mg     = 0;
      eg     = 0;
      pieces = 0;
      for (int s = 0; s < 64; s++)
      begin
         sq   = b[4*s +: 4];
         rank = s / 8;
         pmg  = mg_value(sq[2:0]);
         peg  = eg_value(sq[2:0]);
         if (sq[2:0] == PIECE_PAWN)
            peg = peg + (sq[3] ? ADVANCE * (6 - rank) : ADVANCE * (rank - 1));
         mg = sq[3] ? mg - pmg : mg + pmg;                  // Black counts against
         eg = sq[3] ? eg - peg : eg + peg;
         if (sq[2:0] != PIECE_EMPTY && sq[2:0] != PIECE_PAWN)
            pieces++;
      end
      phase   = (pieces > 62) ? 62 : pieces;
      blended = longint'(mg) * phase + longint'(eg) * (62 - phase);
      scaled  = blended * 16912;
      return score_t'(scaled / 1048576);                    // Truncates toward zero
   endfunction

   function automatic board_t place_piece(input board_t b, input int s, input piece_t p);
      board_t r;
      r = b;
      r[4*s +: 4] = p;
      return r;
   endfunction

   // Rising edge of board_valid, held for one cycle
   task automatic start_board(input board_t b);
      @(negedge clk);
      board_in    = b;
      board_valid = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
   endtask

   // Counts edges after the capture edge until eval_valid is seen
   task automatic wait_valid(output int latency);
      latency = 0;
      while (!eval_valid)
      begin
         @(negedge clk);
         latency++;
         if (latency > MAX_WAIT)
            stop_on_error("Timeout: eval_valid never rose after a board was applied");
      end
   endtask

   task automatic clear_result();
      @(negedge clk);
      clear_eval = 1'b1;
      @(negedge clk);
      clear_eval = 1'b0;
      compare_flag(eval_valid, 1'b0, "after clear");
   endtask

   task automatic evaluate_and_check(input board_t b, input string what);
      int latency;
      start_board(b);
      wait_valid(latency);
      compare_count(latency, 8, what);
      compare_score(eval, expected_eval(b), what);
      @(negedge clk);
      compare_flag(eval_valid, 1'b1, what);                 // Held until cleared
      clear_result();
   endtask

   task automatic test_reset_idle();
      int wait_count;
      wait_count = 0;
      @(negedge clk);                                       // Reset settled by now
      while (reset)
      begin
         @(negedge clk);
         wait_count++;
         if (wait_count > MAX_WAIT)
            stop_on_error("Timeout: reset was never released");
      end
      for (int i = 0; i < 20; i++)
      begin
         @(negedge clk);
         compare_flag(eval_valid, 1'b0, "idle after reset");
      end
   endtask

   task automatic test_start_position();
      board_t b;
      int     latency;
      piece_t back [8];
      back = '{PIECE_ROOK, PIECE_KNIGHT, PIECE_BISHOP, PIECE_QUEEN,
               PIECE_KING, PIECE_BISHOP, PIECE_KNIGHT, PIECE_ROOK};
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b = place_piece(b, f, back[f]);                    // White back rank
         b = place_piece(b, 8 + f, {1'b0, PIECE_PAWN});
         b = place_piece(b, 48 + f, {1'b1, PIECE_PAWN});
         b = place_piece(b, 56 + f, back[f] | 4'b1000);     // Black mirror
      end
      start_board(b);
      wait_valid(latency);
      compare_count(latency, 8, "start position");
      compare_score(eval, score_t'(0), "start position");
      clear_result();
   endtask

   task automatic test_single_pieces();
      board_t b;
      for (int kind = 1; kind <= 6; kind++)
      begin
         for (int color = 0; color < 2; color++)
         begin
            if (kind == 1)
            begin
               for (int rank = 1; rank <= 6; rank++)        // Every pawn rank
               begin
                  b = place_piece('0, rank * 8 + 3, {color[0], 3'd1});
                  evaluate_and_check(b, $sformatf("pawn color %0d rank %0d", color, rank));
               end
            end
            else
            begin
               b = place_piece('0, 28, {color[0], kind[2:0]});
               evaluate_and_check(b, $sformatf("piece %0d color %0d", kind, color));
            end
         end
      end
   endtask

   // Dense boards hold only non-pawn pieces, so the phase saturates
   task automatic make_random_board(input bit dense, output board_t b);
      int kind;
      int color;
      b = '0;
      for (int s = 0; s < 64; s++)
      begin
         if (dense)
            kind = 2 + ($unsigned($random(seed)) % 5);
         else
            kind = $unsigned($random(seed)) % 7;
         color = $random(seed) & 1;
         b = place_piece(b, s, {color[0], kind[2:0]});
      end
   endtask

   task automatic test_random_boards();
      board_t b;
      for (int i = 0; i < RANDOM_RUN; i++)
      begin
         make_random_board(i >= RANDOM_RUN - 5, b);         // Last five are dense
         evaluate_and_check(b, $sformatf("random board %0d", i));
      end
   endtask

   task automatic test_busy_edge_ignored();
      board_t first;
      board_t second;
      score_t held;
      int     latency;
      first  = place_piece('0, 27, {1'b0, PIECE_QUEEN});
      second = place_piece('0, 36, {1'b1, PIECE_ROOK});
      start_board(first);
      wait_valid(latency);
      held = eval;
      compare_score(held, expected_eval(first), "first board");
      start_board(second);                                  // Edge while holding
      repeat (12) @(negedge clk);
      compare_flag(eval_valid, 1'b1, "edge while holding");
      compare_score(eval, held, "edge while holding");
      clear_result();
      evaluate_and_check(second, "board after clear");
   endtask

   initial
   begin
      seed        = 37;
      board_valid = 1'b0;
      board_in    = '0;
      clear_eval  = 1'b0;
      test_reset_idle();
      test_start_position();
      test_single_pieces();
      test_random_boards();
      test_busy_edge_ignored();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- sim/tb_clock.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock
#(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 8                           // Reset held this many edges
)
(
   output logic clk,
   output logic reset
);

   initial clk = 1'b0;

   always #(PERIOD_NS / 2) clk = ~clk;

   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);                                       // Release away from the edge
      reset = 1'b0;
   end

endmodule

//--- verilog/board_eval.sv
////////////////////////////////////////////////////////////
// Chess position evaluator top
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module board_eval
#(
   parameter int PAWN_ADVANCE_EG = 8                        // End-game bonus per rank advanced
)
(
   input  logic             clk,
   input  logic             reset,
   input  logic             board_valid,                    // Rising edge starts an eval
   input  eval_pkg::board_t board_in,
   input  logic             clear_eval,
   output eval_pkg::score_t eval,                           // Positive favours white
   output logic             eval_valid
);
   import eval_pkg::*;

   logic done;                                              // Blend to control

   eval_bus_if bus_i ();

   eval_control ctrl_i
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .done        (done),
      .bus         (bus_i.feed),
      .eval_valid  (eval_valid)
   );

   // One identical scorer per rank
   for (genvar r = 0; r < RANK_COUNT; r++)
   begin : rank_gen
      rank_score
      #(
         .RANK            (r),
         .PAWN_ADVANCE_EG (PAWN_ADVANCE_EG)
      )
      rank_i
      (
         .clk (clk),
         .bus (bus_i.rank)
      );
   end

   phase_blend blend_i
   (
      .clk   (clk),
      .reset (reset),
      .bus   (bus_i.blend),
      .eval  (eval),
      .done  (done)
   );

endmodule

//--- verilog/phase_blend.sv
////////////////////////////////////////////////////////////
// Phase-weighted middle/end game blend
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phase_blend
(
   input  logic             clk,
   input  logic             reset,
   eval_bus_if.blend        bus,
   output eval_pkg::score_t eval,
   output logic             done                           // Eval registered this cycle
);
   import eval_pkg::*;

   localparam int SUM_W    = EVAL_WIDTH + 3;                // Eight rank scores
   localparam int PROD_W   = SUM_W + 7;                     // Times a weight of 0..62
   localparam int BLEND_W  = PROD_W + 1;                    // Two products added
   localparam int SCALED_W = BLEND_W + 16;                  // Times the reciprocal
   localparam logic signed [15:0] RECIP = 16'(PHASE_RECIP);
   localparam logic signed [SCALED_W-1:0] ROUND_BIAS = SCALED_W'((1 << SCALE_SHIFT) - 1);

   logic [6:0]                 token;                       // Bit n set at edge n+1
   logic signed [SUM_W-1:0]    mg_pair [4];
   logic signed [SUM_W-1:0]    eg_pair [4];
   logic [4:0]                 count_pair [4];
   logic signed [SUM_W-1:0]    mg_sum;
   logic signed [SUM_W-1:0]    eg_sum;
   logic [6:0]                 count_total;
   phase_t                     phase;
   logic signed [6:0]          mg_weight;
   logic signed [6:0]          eg_weight;
   logic signed [PROD_W-1:0]   mg_prod;
   logic signed [PROD_W-1:0]   eg_prod;
   logic signed [BLEND_W-1:0]  blend;
   logic signed [SCALED_W-1:0] scaled;
   logic signed [SCALED_W-1:0] biased;

   // Start token rides alongside the data, one bit per stage
   always_ff @(posedge clk)
   begin
      if (reset)
         token <= '0;
      else
         token <= {token[5:0], bus.start};
   end

   assign done = token[6];

   assign count_total = count_pair[0] + count_pair[1] + count_pair[2] + count_pair[3];
   assign mg_weight   = {1'b0, phase};
   assign eg_weight   = 7'(PHASE_MAX) - {1'b0, phase};       // Never negative

   // Bias negatives up so the shift truncates toward zero
   assign biased = scaled[SCALED_W-1] ? scaled + ROUND_BIAS : scaled;

   always_ff @(posedge clk)
   begin
      // Edge 2, pair sums
      for (int i = 0; i < RANK_COUNT / 2; i++)
      begin
         mg_pair[i]    <= bus.rank_mg[2*i] + bus.rank_mg[2*i+1];
         eg_pair[i]    <= bus.rank_eg[2*i] + bus.rank_eg[2*i+1];
         count_pair[i] <= bus.rank_count[2*i] + bus.rank_count[2*i+1];
      end

      // Edge 3, full sums and phase clamp
      mg_sum <= mg_pair[0] + mg_pair[1] + mg_pair[2] + mg_pair[3];
      eg_sum <= eg_pair[0] + eg_pair[1] + eg_pair[2] + eg_pair[3];
      if (count_total > 7'(PHASE_MAX))
         phase <= phase_t'(PHASE_MAX);
      else
         phase <= phase_t'(count_total);

      // Edge 4, weight each game stage
      mg_prod <= mg_sum * mg_weight;
      eg_prod <= eg_sum * eg_weight;

      // Edge 5
      blend <= mg_prod + eg_prod;

      // Edge 6, multiply by 2^20 / 62 in place of a divide
      scaled <= blend * RECIP;

      // Edge 7
      eval <= score_t'(biased >>> SCALE_SHIFT);
   end

   // Scaled width holds the largest blend, so the sign survives the multiply
   assert property (@(posedge clk) disable iff (reset)
      $past(blend) != '0 |-> scaled != '0 && scaled[SCALED_W-1] == $past(blend[BLEND_W-1]));

endmodule

//--- verilog/rank_score.sv
////////////////////////////////////////////////////////////
// One-rank material scorer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rank_score
#(
   parameter int RANK            = 0,                       // 0 is the white back rank
   parameter int PAWN_ADVANCE_EG = 8                        // End-game bonus per rank
)
(
   input  logic     clk,
   eval_bus_if.rank bus
);
   import eval_pkg::*;

   // Advance bonus for a pawn standing on this rank
   localparam int WHITE_PAWN_EG = PAWN_ADVANCE_EG * (RANK - 1); // White starts on rank 1
   localparam int BLACK_PAWN_EG = PAWN_ADVANCE_EG * (6 - RANK); // Black starts on rank 6

   piece_t     square;
   logic [2:0] kind;
   int         piece_mg;
   int         piece_eg;
   int         mg_acc;
   int         eg_acc;
   count_t     count_acc;

   score_t     mg_r;
   score_t     eg_r;
   count_t     count_r;

   always_comb
   begin
      mg_acc    = 0;
      eg_acc    = 0;
      count_acc = '0;
      for (int f = 0; f < FILE_COUNT; f++)
      begin
         square   = bus.board[(RANK * FILE_COUNT + f) * PIECE_WIDTH +: PIECE_WIDTH];
         kind     = square[2:0];
         piece_mg = MG_VALUE[kind];
         piece_eg = EG_VALUE[kind];
         if (kind == PIECE_PAWN)
            piece_eg = piece_eg + (square[3] ? BLACK_PAWN_EG : WHITE_PAWN_EG);
         if (square[3])                                     // Black counts against
         begin
            mg_acc = mg_acc - piece_mg;
            eg_acc = eg_acc - piece_eg;
         end
         else
         begin
            mg_acc = mg_acc + piece_mg;
            eg_acc = eg_acc + piece_eg;
         end
         if (kind != PIECE_EMPTY && kind != PIECE_PAWN)     // Kings included
            count_acc = count_acc + 4'd1;
      end
   end

   // Edge 1 of the evaluation
   always_ff @(posedge clk)
   begin
      mg_r    <= score_t'(mg_acc);
      eg_r    <= score_t'(eg_acc);
      count_r <= count_acc;
   end

   assign bus.rank_mg[RANK]    = mg_r;
   assign bus.rank_eg[RANK]    = eg_r;
   assign bus.rank_count[RANK] = count_r;

   assert property (@(posedge clk) count_r <= 4'd8);

endmodule

//--- verilog/eval_control.sv
////////////////////////////////////////////////////////////
// Evaluator control
// Board capture and valid/clear handshake
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module eval_control
(
   input  logic             clk,
   input  logic             reset,
   input  logic             board_valid,
   input  eval_pkg::board_t board_in,
   input  logic             clear_eval,
   input  logic             done,                           // From blend, last stage
   eval_bus_if.feed         bus,
   output logic             eval_valid
);

   typedef enum logic [1:0]
   {
      ST_IDLE,                                              // Waiting for a board
      ST_BUSY,                                              // Token in flight
      ST_HOLD                                               // Result presented
   } state_t;

   state_t state;
   logic   board_valid_r;                                   // Previous board_valid
   logic   board_rise;

   assign board_rise = board_valid & ~board_valid_r;        // Rising edge only

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= ST_IDLE;
         board_valid_r <= 1'b0;
         bus.start     <= 1'b0;
         eval_valid    <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         bus.start     <= 1'b0;                             // Strobe by default
         case (state)
            ST_IDLE:
            begin
               if (board_rise)
               begin
                  bus.start <= 1'b1;
                  state     <= ST_BUSY;
               end
            end
            ST_BUSY:
            begin
               if (done)                                    // Eval register now stable
               begin
                  eval_valid <= 1'b1;
                  state      <= ST_HOLD;
               end
            end
            ST_HOLD:
            begin
               if (clear_eval)
               begin
                  eval_valid <= 1'b0;
                  state      <= ST_IDLE;
               end
            end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // Board is only taken in idle, edges while busy or holding are dropped
   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && board_rise)
         bus.board <= board_in;
   end

   // The only token in the blend pipe is the one this FSM launched
   assert property (@(posedge clk) disable iff (reset) done |-> state == ST_BUSY);
   assert property (@(posedge clk) disable iff (reset) bus.start |-> !done);

endmodule

//--- verilog/eval_bus_if.sv
////////////////////////////////////////////////////////////
// Control, rank scorer and blend bus
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface eval_bus_if;
   import eval_pkg::*;

   board_t board;                                           // Captured board
   logic   start;                                           // One-cycle start token
   score_t rank_mg    [RANK_COUNT];                         // Per-rank middle-game sum
   score_t rank_eg    [RANK_COUNT];                         // Per-rank end-game sum
   count_t rank_count [RANK_COUNT];                         // Per-rank non-pawn count

   modport feed
   (
      output board,
      output start
   );

   modport rank
   (
      input  board,
      output rank_mg,
      output rank_eg,
      output rank_count
   );

   modport blend
   (
      input start,
      input rank_mg,
      input rank_eg,
      input rank_count
   );

endinterface

//--- verilog/eval_pkg.sv
////////////////////////////////////////////////////////////
// Board evaluator shared definitions
////////////////////////////////////////////////////////////

package eval_pkg;

   // Board geometry
   localparam int RANK_COUNT  = 8;
   localparam int FILE_COUNT  = 8;
   localparam int PIECE_WIDTH = 4;                          // Color bit plus 3-bit type
   localparam int BOARD_WIDTH = RANK_COUNT * FILE_COUNT * PIECE_WIDTH;

   // Score and blend constants
   localparam int EVAL_WIDTH  = 16;
   localparam int PHASE_MAX   = 62;                         // Phase saturates here
   localparam int SCALE_SHIFT = 20;
   localparam int PHASE_RECIP = (1 << SCALE_SHIFT) / PHASE_MAX; // 16912, rounded down

   // Piece type codes, bits 2..0 of a square
   localparam logic [2:0] PIECE_EMPTY  = 3'd0;
   localparam logic [2:0] PIECE_PAWN   = 3'd1;
   localparam logic [2:0] PIECE_KNIGHT = 3'd2;
   localparam logic [2:0] PIECE_BISHOP = 3'd3;
   localparam logic [2:0] PIECE_ROOK   = 3'd4;
   localparam logic [2:0] PIECE_QUEEN  = 3'd5;
   localparam logic [2:0] PIECE_KING   = 3'd6;

   // Bit 3 set means black
   typedef logic [PIECE_WIDTH-1:0] piece_t;

   // Square s sits at bits 4s+3..4s, rank 0 is the white back rank
   typedef logic [BOARD_WIDTH-1:0] board_t;

   typedef logic signed [EVAL_WIDTH-1:0] score_t;         // Rank scores, sums, final eval
   typedef logic [3:0]                   count_t;         // Non-pawn pieces on one rank
   typedef logic [5:0]                   phase_t;         // Game phase 0..62

   // Middle-game material, indexed by piece type
   localparam int MG_VALUE [8] = '{
      0,                                                    // Empty
      82,                                                   // Pawn
      337,                                                  // Knight
      365,                                                  // Bishop
      477,                                                  // Rook
      1025,                                                 // Queen
      0,                                                    // King
      0                                                     // Unused code
   };

   // End-game material, indexed by piece type
   localparam int EG_VALUE [8] = '{
      0,
      94,
      281,
      297,
      512,
      936,
      0,
      0
   };

endpackage
